// File: soc_bus_pkg.sv
package soc_bus_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;
  typedef logic [2:0]  size_t;   // AXI size code, 0 byte, 1 half, 2 word.
  typedef logic [1:0]  resp_t;
  typedef logic [63:0] mtime_t;
  typedef logic [1:0]  burst_t;
  typedef logic [3:0]  axi_id_t;

  localparam addr_t clint_mtime_lo_addr = 32'h0200_0048;
  localparam addr_t clint_mtime_hi_addr = 32'h0200_004c;

  localparam int unsigned fetch_beats = 2;   // one instruction pair per fetch.

  localparam size_t   size_word      = 3'd2;
  localparam resp_t   axi_resp_okay  = 2'b00;
  localparam burst_t  axi_burst_incr = 2'b01;
  localparam axi_id_t axi_id_zero    = 4'd0;

  typedef struct packed {
    addr_t      addr;
    size_t      size;
    logic [7:0] len;
    logic       valid;
  } ar_req_t;

  typedef struct packed {
    data_t data;
    resp_t resp;
    logic  last;
    logic  valid;
  } r_rsp_t;

  typedef struct packed {
    addr_t addr;
    size_t size;
    logic  valid;
  } aw_req_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  valid;
  } w_req_t;

  typedef struct packed {
    resp_t resp;
    logic  valid;
  } b_rsp_t;

  typedef enum logic [1:0] {arb_idle, arb_fetch, arb_lsu} arb_state_e;

  typedef enum logic [1:0] {port_idle, port_addr, port_data, port_resp} port_state_e;

endpackage

// File: fetch_port.sv
`timescale 1ns/1ps

module fetch_port (
  input  logic                  clock,
  input  logic                  reset,
  input  soc_bus_pkg::addr_t    req_addr,
  input  logic                  req_valid,
  output logic                  req_ready,
  output soc_bus_pkg::ar_req_t  ar,
  input  logic                  ar_ready,
  input  soc_bus_pkg::r_rsp_t   r,
  output logic                  r_ready,
  output soc_bus_pkg::r_rsp_t   rsp,
  input  logic                  rsp_ready,
  output logic                  enable
);
  import soc_bus_pkg::*;

  port_state_e state;
  addr_t       addr_q;
  logic [1:0]  beat_cnt;
  logic        r_fire;

  assign r_fire = (state == port_data) && r.valid && rsp_ready;

  always_ff @(posedge clock) begin
    if (reset) begin
      state    <= port_idle;
      beat_cnt <= 2'd0;
    end else begin
      case (state)
        port_idle: begin
          if (req_valid) begin
            state <= port_addr;
          end
        end
        port_addr: begin
          beat_cnt <= 2'd0;
          if (ar_ready) begin
            state <= port_data;
          end
        end
        port_data: begin
          if (r_fire) begin
            beat_cnt <= beat_cnt + 2'd1;
            if (r.last) begin
              state <= port_idle;   // enable falls and the arbiter lets go.
            end
          end
        end
        default: state <= port_idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == port_idle && req_valid) begin
      addr_q <= {req_addr[31:2], 2'b00};
    end
  end

  assign req_ready = (state == port_idle);
  assign enable    = (state != port_idle);

  assign ar = '{addr: addr_q, size: size_word, len: 8'(fetch_beats - 1),
                valid: (state == port_addr)};

  // beats go straight through, so the requester's ready stalls the slave.
  assign r_ready = (state == port_data) && rsp_ready;
  assign rsp     = '{data: r.data, resp: r.resp, last: r.last,
                     valid: (state == port_data) && r.valid};

  a_last_on_final_beat: assert property (
    @(posedge clock) disable iff (reset)
    r_fire |-> (r.last == (beat_cnt == 2'(fetch_beats - 1)))
  ) else $error("fetch burst last does not match beat %0d", beat_cnt);

endmodule

// File: load_store_port.sv
`timescale 1ns/1ps

module load_store_port (
  input  logic                  clock,
  input  logic                  reset,
  input  soc_bus_pkg::addr_t    req_addr,
  input  logic                  req_write,
  input  soc_bus_pkg::size_t    req_size,
  input  soc_bus_pkg::data_t    req_wdata,
  input  logic                  req_valid,
  output logic                  req_ready,
  output soc_bus_pkg::ar_req_t  ar,
  input  logic                  ar_ready,
  input  soc_bus_pkg::r_rsp_t   r,
  output logic                  r_ready,
  output soc_bus_pkg::aw_req_t  aw,
  input  logic                  aw_ready,
  output soc_bus_pkg::w_req_t   w,
  input  logic                  w_ready,
  input  soc_bus_pkg::b_rsp_t   b,
  output logic                  b_ready,
  output soc_bus_pkg::data_t    rsp_data,
  output soc_bus_pkg::resp_t    rsp_resp,
  output logic                  rsp_valid,
  input  logic                  rsp_ready,
  output logic                  enable
);
  import soc_bus_pkg::*;

  port_state_e state;
  addr_t       addr_q;
  size_t       size_q;
  logic        write_q;
  data_t       wdata_q;
  strb_t       strb_q;
  strb_t       strb_d;
  logic        aw_done;
  logic        w_done;
  logic        aw_fire;
  logic        w_fire;

  always_comb begin
    case (req_size)
      3'd0:    strb_d = strb_t'(4'b0001 << req_addr[1:0]);
      3'd1:    strb_d = strb_t'(4'b0011 << {req_addr[1], 1'b0});
      default: strb_d = 4'b1111;
    endcase
  end

  assign aw_fire = aw.valid && aw_ready;
  assign w_fire  = w.valid && w_ready;

  always_ff @(posedge clock) begin
    if (reset) begin
      state   <= port_idle;
      aw_done <= 1'b0;
      w_done  <= 1'b0;
    end else begin
      case (state)
        port_idle: begin
          aw_done <= 1'b0;
          w_done  <= 1'b0;
          if (req_valid) begin
            state <= port_addr;
          end
        end
        port_addr: begin
          if (write_q) begin
            // the slave may take AW and W in either order.
            if (aw_fire) begin
              aw_done <= 1'b1;
            end
            if (w_fire) begin
              w_done <= 1'b1;
            end
            if ((aw_done || aw_fire) && (w_done || w_fire)) begin
              state <= port_resp;
            end
          end else if (ar_ready) begin
            state <= port_data;
          end
        end
        port_data: begin
          if (r.valid && rsp_ready) begin
            state <= port_idle;
          end
        end
        port_resp: begin
          if (b.valid && rsp_ready) begin
            state <= port_idle;
          end
        end
        default: state <= port_idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == port_idle && req_valid) begin
      addr_q  <= req_addr;
      size_q  <= req_size;
      write_q <= req_write;
      wdata_q <= req_wdata << {req_addr[1:0], 3'b000};   // move data onto its lane.
      strb_q  <= strb_d;
    end
  end

  assign req_ready = (state == port_idle);
  assign enable    = (state != port_idle);

  assign ar = '{addr: addr_q, size: size_q, len: 8'd0,
                valid: (state == port_addr) && !write_q};
  assign aw = '{addr: addr_q, size: size_q,
                valid: (state == port_addr) && write_q && !aw_done};
  assign w  = '{data: wdata_q, strb: strb_q,
                valid: (state == port_addr) && write_q && !w_done};

  assign r_ready   = (state == port_data) && rsp_ready;
  assign b_ready   = (state == port_resp) && rsp_ready;
  assign rsp_valid = ((state == port_data) && r.valid) || ((state == port_resp) && b.valid);
  assign rsp_data  = (state == port_data) ? r.data : '0;   // read data keeps its lane.
  assign rsp_resp  = (state == port_resp) ? b.resp : r.resp;

  a_strobe_matches_size: assert property (
    @(posedge clock) disable iff (reset)
    w.valid |-> ($countones(w.strb) == (1 << aw.size))
  ) else $error("write strobe %b does not fit size %0d", w.strb, aw.size);

endmodule

// File: clint_timer.sv
`timescale 1ns/1ps

module clint_timer (
  input  logic                  clock,
  input  logic                  reset,
  input  soc_bus_pkg::ar_req_t  ar,
  output logic                  ar_ready,
  output soc_bus_pkg::r_rsp_t   r,
  input  logic                  r_ready
);
  import soc_bus_pkg::*;

  mtime_t mtime;
  data_t  rdata_q;
  logic   rvalid_q;
  logic   ar_fire;

  assign ar_fire = ar.valid && ar_ready;

  always_ff @(posedge clock) begin
    if (reset) begin
      mtime <= '0;
    end else begin
      mtime <= mtime + 64'd1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      rvalid_q <= 1'b0;
    end else if (ar_fire) begin
      rvalid_q <= 1'b1;
    end else if (r_ready) begin
      rvalid_q <= 1'b0;
    end
  end

  // the word is sampled at acceptance and held until the reader takes it.
  always_ff @(posedge clock) begin
    if (ar_fire) begin
      rdata_q <= (ar.addr == clint_mtime_hi_addr) ? mtime[63:32] : mtime[31:0];
    end
  end

  assign ar_ready = !rvalid_q;
  assign r        = '{data: rdata_q, resp: axi_resp_okay, last: 1'b1, valid: rvalid_q};

  a_clint_address: assert property (
    @(posedge clock) disable iff (reset)
    ar_fire |-> (ar.addr == clint_mtime_lo_addr || ar.addr == clint_mtime_hi_addr)
  ) else $error("timer read at %h is not an mtime word", ar.addr);

endmodule

// File: bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  fetch_enable,
  input  logic                  lsu_enable,
  input  soc_bus_pkg::ar_req_t  fetch_ar,
  output logic                  fetch_ar_ready,
  output soc_bus_pkg::r_rsp_t   fetch_r,
  input  logic                  fetch_r_ready,
  input  soc_bus_pkg::ar_req_t  lsu_ar,
  output logic                  lsu_ar_ready,
  output soc_bus_pkg::r_rsp_t   lsu_r,
  input  logic                  lsu_r_ready,
  input  soc_bus_pkg::aw_req_t  lsu_aw,
  output logic                  lsu_aw_ready,
  input  soc_bus_pkg::w_req_t   lsu_w,
  output logic                  lsu_w_ready,
  output soc_bus_pkg::b_rsp_t   lsu_b,
  input  logic                  lsu_b_ready,
  output soc_bus_pkg::ar_req_t  clint_ar,
  input  logic                  clint_ar_ready,
  input  soc_bus_pkg::r_rsp_t   clint_r,
  output logic                  clint_r_ready,
  output soc_bus_pkg::ar_req_t  m_ar,
  output soc_bus_pkg::burst_t   m_ar_burst,
  output soc_bus_pkg::axi_id_t  m_ar_id,
  input  logic                  m_ar_ready,
  input  soc_bus_pkg::r_rsp_t   m_r,
  output logic                  m_r_ready,
  output soc_bus_pkg::aw_req_t  m_aw,
  output soc_bus_pkg::burst_t   m_aw_burst,
  output soc_bus_pkg::axi_id_t  m_aw_id,
  input  logic                  m_aw_ready,
  output soc_bus_pkg::w_req_t   m_w,
  output logic                  m_w_last,
  input  logic                  m_w_ready,
  input  soc_bus_pkg::b_rsp_t   m_b,
  output logic                  m_b_ready
);
  import soc_bus_pkg::*;

  arb_state_e state;
  logic       is_clint;
  logic       fetch_sel;
  logic       lsu_sel;
  logic       lsu_mem;
  logic       lsu_clint;

  always_ff @(posedge clock) begin
    if (reset) begin
      state    <= arb_idle;
      is_clint <= 1'b0;
    end else begin
      case (state)
        arb_idle: begin
          if (lsu_enable) begin
            state    <= arb_lsu;   // loads and stores win over fetch.
            is_clint <= lsu_ar.valid && (lsu_ar.addr == clint_mtime_lo_addr ||
                                         lsu_ar.addr == clint_mtime_hi_addr);
          end else if (fetch_enable) begin
            state <= arb_fetch;
          end
        end
        arb_fetch: begin
          if (!fetch_enable) begin
            state <= arb_idle;
          end
        end
        arb_lsu: begin
          if (!lsu_enable) begin
            state <= arb_idle;
          end
        end
        default: state <= arb_idle;
      endcase
    end
  end

  assign fetch_sel = (state == arb_fetch);
  assign lsu_sel   = (state == arb_lsu);
  assign lsu_mem   = lsu_sel && !is_clint;
  assign lsu_clint = lsu_sel && is_clint;

  always_comb begin
    m_ar       = fetch_sel ? fetch_ar : lsu_ar;
    m_ar.len   = fetch_sel ? 8'(fetch_beats - 1) : 8'd0;
    m_ar.valid = (fetch_sel && fetch_ar.valid) || (lsu_mem && lsu_ar.valid);

    clint_ar       = lsu_ar;
    clint_ar.valid = lsu_clint && lsu_ar.valid;

    fetch_r       = m_r;
    fetch_r.valid = fetch_sel && m_r.valid;

    lsu_r       = is_clint ? clint_r : m_r;
    lsu_r.valid = lsu_sel && (is_clint ? clint_r.valid : m_r.valid);

    m_aw       = lsu_aw;
    m_aw.valid = lsu_sel && lsu_aw.valid;
    m_w        = lsu_w;
    m_w.valid  = lsu_sel && lsu_w.valid;
    lsu_b       = m_b;
    lsu_b.valid = lsu_sel && m_b.valid;
  end

  assign m_ar_burst = axi_burst_incr;
  assign m_ar_id    = axi_id_zero;
  assign m_aw_burst = axi_burst_incr;
  assign m_aw_id    = axi_id_zero;
  assign m_w_last   = m_w.valid;   // writes are always one beat.

  assign fetch_ar_ready = fetch_sel && m_ar_ready;
  assign lsu_ar_ready   = lsu_sel && (is_clint ? clint_ar_ready : m_ar_ready);
  assign lsu_aw_ready   = lsu_sel && m_aw_ready;
  assign lsu_w_ready    = lsu_sel && m_w_ready;
  assign clint_r_ready  = lsu_clint && lsu_r_ready;
  assign m_r_ready      = fetch_sel ? fetch_r_ready : (lsu_mem && lsu_r_ready);
  assign m_b_ready      = lsu_sel && lsu_b_ready;

  a_clint_route: assert property (
    @(posedge clock) disable iff (reset)
    (lsu_sel && lsu_ar.valid) |->
      (is_clint == (lsu_ar.addr == clint_mtime_lo_addr ||
                    lsu_ar.addr == clint_mtime_hi_addr))
  ) else $error("load at %h is routed to the wrong slave", lsu_ar.addr);

  a_ar_held: assert property (
    @(posedge clock) disable iff (reset)
    (m_ar.valid && !m_ar_ready) |=> (m_ar.valid && $stable(m_ar))
  ) else $error("external read address changed before it was accepted");

endmodule

// File: soc_bus_top.sv
`timescale 1ns/1ps

module soc_bus_top (
  input  logic                  clock,
  input  logic                  reset,
  input  soc_bus_pkg::addr_t    fetch_req_addr,
  input  logic                  fetch_req_valid,
  output logic                  fetch_req_ready,
  output soc_bus_pkg::r_rsp_t   fetch_rsp,
  input  logic                  fetch_rsp_ready,
  input  soc_bus_pkg::addr_t    lsu_req_addr,
  input  logic                  lsu_req_write,
  input  soc_bus_pkg::size_t    lsu_req_size,
  input  soc_bus_pkg::data_t    lsu_req_wdata,
  input  logic                  lsu_req_valid,
  output logic                  lsu_req_ready,
  output soc_bus_pkg::data_t    lsu_rsp_data,
  output soc_bus_pkg::resp_t    lsu_rsp_resp,
  output logic                  lsu_rsp_valid,
  input  logic                  lsu_rsp_ready,
  output soc_bus_pkg::ar_req_t  m_ar,
  output soc_bus_pkg::burst_t   m_ar_burst,
  output soc_bus_pkg::axi_id_t  m_ar_id,
  input  logic                  m_ar_ready,
  input  soc_bus_pkg::r_rsp_t   m_r,
  output logic                  m_r_ready,
  output soc_bus_pkg::aw_req_t  m_aw,
  output soc_bus_pkg::burst_t   m_aw_burst,
  output soc_bus_pkg::axi_id_t  m_aw_id,
  input  logic                  m_aw_ready,
  output soc_bus_pkg::w_req_t   m_w,
  output logic                  m_w_last,
  input  logic                  m_w_ready,
  input  soc_bus_pkg::b_rsp_t   m_b,
  output logic                  m_b_ready
);
  import soc_bus_pkg::*;

  logic    fetch_enable;
  logic    lsu_enable;
  ar_req_t fetch_ar;
  logic    fetch_ar_ready;
  r_rsp_t  fetch_r;
  logic    fetch_r_ready;
  ar_req_t lsu_ar;
  logic    lsu_ar_ready;
  r_rsp_t  lsu_r;
  logic    lsu_r_ready;
  aw_req_t lsu_aw;
  logic    lsu_aw_ready;
  w_req_t  lsu_w;
  logic    lsu_w_ready;
  b_rsp_t  lsu_b;
  logic    lsu_b_ready;
  ar_req_t clint_ar;
  logic    clint_ar_ready;
  r_rsp_t  clint_r;
  logic    clint_r_ready;

  fetch_port fetch_port_i (
    .clock     (clock),
    .reset     (reset),
    .req_addr  (fetch_req_addr),
    .req_valid (fetch_req_valid),
    .req_ready (fetch_req_ready),
    .ar        (fetch_ar),
    .ar_ready  (fetch_ar_ready),
    .r         (fetch_r),
    .r_ready   (fetch_r_ready),
    .rsp       (fetch_rsp),
    .rsp_ready (fetch_rsp_ready),
    .enable    (fetch_enable)
  );

  load_store_port load_store_port_i (
    .clock     (clock),
    .reset     (reset),
    .req_addr  (lsu_req_addr),
    .req_write (lsu_req_write),
    .req_size  (lsu_req_size),
    .req_wdata (lsu_req_wdata),
    .req_valid (lsu_req_valid),
    .req_ready (lsu_req_ready),
    .ar        (lsu_ar),
    .ar_ready  (lsu_ar_ready),
    .r         (lsu_r),
    .r_ready   (lsu_r_ready),
    .aw        (lsu_aw),
    .aw_ready  (lsu_aw_ready),
    .w         (lsu_w),
    .w_ready   (lsu_w_ready),
    .b         (lsu_b),
    .b_ready   (lsu_b_ready),
    .rsp_data  (lsu_rsp_data),
    .rsp_resp  (lsu_rsp_resp),
    .rsp_valid (lsu_rsp_valid),
    .rsp_ready (lsu_rsp_ready),
    .enable    (lsu_enable)
  );

  bus_arbiter bus_arbiter_i (.*);   // internal wires carry the arbiter's port names.

  clint_timer clint_timer_i (
    .clock    (clock),
    .reset    (reset),
    .ar       (clint_ar),
    .ar_ready (clint_ar_ready),
    .r        (clint_r),
    .r_ready  (clint_r_ready)
  );

endmodule

// File: tb_axi_memory.sv
`timescale 1ns/1ps

module tb_axi_memory #(
  parameter logic [31:0] seed = 32'h985c30ac
) (
  input  logic                  clock,
  input  logic                  reset,
  input  soc_bus_pkg::ar_req_t  ar,
  output logic                  ar_ready,
  output soc_bus_pkg::r_rsp_t   r,
  input  logic                  r_ready,
  input  soc_bus_pkg::aw_req_t  aw,
  output logic                  aw_ready,
  input  soc_bus_pkg::w_req_t   w,
  output logic                  w_ready,
  output soc_bus_pkg::b_rsp_t   b,
  input  logic                  b_ready
);
  import soc_bus_pkg::*;

  data_t       store [addr_t];
  logic [31:0] rand_state;
  logic [1:0]  ar_stall;
  logic [1:0]  aw_stall;
  addr_t       rd_next;
  logic [7:0]  rd_left;
  logic        aw_have;
  logic        w_have;
  addr_t       aw_addr;
  w_req_t      w_held;

  function automatic logic [31:0] next_random(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // unwritten words read back as their own address with a fixed mask.
  function automatic data_t read_word(input addr_t addr);
    addr_t key;
    key = {addr[31:2], 2'b00};
    if (store.exists(key)) begin
      return store[key];
    end
    return key ^ 32'h5a5a_0000;
  endfunction

  function automatic data_t merge_word(input data_t old, input w_req_t wr);
    data_t word;
    int    i;
    word = old;
    for (i = 0; i < 4; i++) begin
      if (wr.strb[i]) begin
        word[8 * i +: 8] = wr.data[8 * i +: 8];
      end
    end
    return word;
  endfunction

  always @(posedge clock) begin
    if (reset) begin
      ar_ready   <= 1'b0;
      aw_ready   <= 1'b0;
      w_ready    <= 1'b0;
      r          <= '0;
      b          <= '0;
      ar_stall   <= 2'd0;
      aw_stall   <= 2'd0;
      rd_left    <= 8'd0;
      aw_have    <= 1'b0;
      w_have     <= 1'b0;
      rand_state <= seed;
    end else begin
      rand_state <= next_random(rand_state);
      ar_ready   <= 1'b0;
      aw_ready   <= 1'b0;
      w_ready    <= 1'b0;
      if (ar.valid && ar_ready) begin
        r        <= '{data: read_word(ar.addr), resp: 2'b00, last: (ar.len == 8'd0),
                      valid: 1'b1};
        rd_next  <= ar.addr + 32'd4;
        rd_left  <= ar.len;
        ar_stall <= 2'(rand_state[31:16] % 3);
      end else if (r.valid && r_ready) begin
        if (rd_left != 8'd0) begin
          r       <= '{data: read_word(rd_next), resp: 2'b00, last: (rd_left == 8'd1),
                       valid: 1'b1};
          rd_next <= rd_next + 32'd4;
          rd_left <= rd_left - 8'd1;
        end else begin
          r.valid <= 1'b0;
        end
      end else if (ar.valid && !r.valid) begin
        if (ar_stall == 2'd0) begin
          ar_ready <= 1'b1;
        end else begin
          ar_stall <= ar_stall - 2'd1;
        end
      end
      if (aw.valid && aw_ready) begin
        aw_have  <= 1'b1;
        aw_addr  <= aw.addr;
        aw_stall <= 2'(rand_state[15:8] % 3);
      end else if (aw.valid && !aw_have && !b.valid) begin
        if (aw_stall == 2'd0) begin
          aw_ready <= 1'b1;
        end else begin
          aw_stall <= aw_stall - 2'd1;
        end
      end
      if (w.valid && w_ready) begin
        w_have <= 1'b1;
        w_held <= w;
      end else if (w.valid && !w_have && !b.valid) begin
        w_ready <= 1'b1;   // data is taken at once, so it often beats its address.
      end
      if (aw_have && w_have) begin
        store[{aw_addr[31:2], 2'b00}] = merge_word(read_word(aw_addr), w_held);
        b       <= '{resp: 2'b00, valid: 1'b1};
        aw_have <= 1'b0;
        w_have  <= 1'b0;
      end else if (b.valid && b_ready) begin
        b.valid <= 1'b0;
      end
    end
  end

endmodule

// File: tb_soc_bus.sv
`timescale 1ns/1ps

module tb_soc_bus;
  import soc_bus_pkg::*;

  typedef enum logic [1:0] {check_write, check_read, check_lo, check_hi} lsu_check_e;
  typedef enum {fetch_accept, fetch_valid, fetch_last, lsu_accept, lsu_response} wait_event_e;

  localparam addr_t window_base = 32'h0001_0000;
  localparam int    wait_limit  = 200;

  logic       clock;
  logic       reset;
  addr_t      fetch_req_addr;
  logic       fetch_req_valid;
  logic       fetch_req_ready;
  r_rsp_t     fetch_rsp;
  logic       fetch_rsp_ready;
  addr_t      lsu_req_addr;
  logic       lsu_req_write;
  size_t      lsu_req_size;
  data_t      lsu_req_wdata;
  logic       lsu_req_valid;
  logic       lsu_req_ready;
  data_t      lsu_rsp_data;
  resp_t      lsu_rsp_resp;
  logic       lsu_rsp_valid;
  logic       lsu_rsp_ready;
  ar_req_t    m_ar;
  burst_t     m_ar_burst;
  axi_id_t    m_ar_id;
  logic       m_ar_ready;
  r_rsp_t     m_r;
  logic       m_r_ready;
  aw_req_t    m_aw;
  burst_t     m_aw_burst;
  axi_id_t    m_aw_id;
  logic       m_aw_ready;
  w_req_t     m_w;
  logic       m_w_last;
  logic       m_w_ready;
  b_rsp_t     m_b;
  logic       m_b_ready;

  data_t       shadow [addr_t];
  logic [31:0] rand_state = 32'h985c30ac;
  int          error_count = 0;
  data_t       fetch_first;
  data_t       fetch_second;
  logic        fetch_beat;
  logic        fetch_on_bus;
  lsu_check_e  lsu_mode = check_write;
  data_t       lsu_expect;
  data_t       last_lo;
  logic        lsu_first_pending = 1'b0;

  soc_bus_top dut_i (.*);

  tb_axi_memory #(.seed(32'h985c30ac)) memory_i (
    .clock    (clock),
    .reset    (reset),
    .ar       (m_ar),
    .ar_ready (m_ar_ready),
    .r        (m_r),
    .r_ready  (m_r_ready),
    .aw       (m_aw),
    .aw_ready (m_aw_ready),
    .w        (m_w),
    .w_ready  (m_w_ready),
    .b        (m_b),
    .b_ready  (m_b_ready)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  function automatic logic [31:0] next_random(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic addr_t random_address();
    rand_state = next_random(rand_state);
    return window_base | (addr_t'(rand_state[27:18]) << 2);
  endfunction

  function automatic data_t expected_word(input addr_t addr);
    if (shadow.exists(addr)) begin
      return shadow[addr];
    end
    return addr ^ 32'h5a5a_0000;
  endfunction

  task automatic record_write(input addr_t addr, input size_t size, input data_t wdata);
    addr_t key;
    data_t word;
    int    i;
    key  = {addr[31:2], 2'b00};
    word = expected_word(key);
    for (i = 0; i < (1 << size); i++) begin
      word[8 * (int'(addr[1:0]) + i) +: 8] = wdata[8 * i +: 8];   // low address bits pick the lane.
    end
    shadow[key] = word;
  endtask

  task automatic log_error(input string msg);
    error_count++;
    $display("Error at %0d ns: %s", $time, msg);
  endtask

  function automatic logic event_seen(input wait_event_e ev);
    case (ev)
      fetch_accept: return fetch_req_valid && fetch_req_ready;
      fetch_valid:  return fetch_rsp.valid;
      fetch_last:   return fetch_rsp.valid && fetch_rsp_ready && fetch_rsp.last;
      lsu_accept:   return lsu_req_valid && lsu_req_ready;
      default:      return lsu_rsp_valid && lsu_rsp_ready;
    endcase
  endfunction

  task automatic wait_until(input wait_event_e ev, input string what);
    int   cycles;
    logic seen;
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < wait_limit) begin
      @(posedge clock);
      cycles++;
      seen = event_seen(ev);
    end
    if (!seen) begin
      $display("Timeout after %0d cycles while waiting for the %s", cycles, what);
      $display("Simulation FAILED");
      $finish;
    end
  endtask

  task automatic start_fetch(input addr_t addr);
    fetch_first     = expected_word(addr);
    fetch_second    = expected_word(addr + 32'd4);
    fetch_req_addr  <= addr;
    fetch_req_valid <= 1'b1;
    wait_until(fetch_accept, "fetch request to be accepted");
    fetch_req_valid <= 1'b0;
  endtask

  task automatic lsu_access(input logic write, input size_t size, input addr_t addr,
                            input data_t wdata);
    if (write) begin
      lsu_mode = check_write;
      record_write(addr, size, wdata);
    end else if (addr == clint_mtime_lo_addr) begin
      lsu_mode = check_lo;
    end else if (addr == clint_mtime_hi_addr) begin
      lsu_mode = check_hi;
    end else begin
      lsu_mode   = check_read;
      lsu_expect = expected_word(addr);
    end
    lsu_req_addr  <= addr;
    lsu_req_write <= write;
    lsu_req_size  <= size;
    lsu_req_wdata <= wdata;
    lsu_req_valid <= 1'b1;
    wait_until(lsu_accept, "load/store request to be accepted");
    lsu_req_valid <= 1'b0;
    wait_until(lsu_response, "load/store response");
  endtask

  always @(posedge clock) begin
    if (reset) begin
      fetch_beat   <= 1'b0;
      fetch_on_bus <= 1'b0;
      last_lo      <= '0;
    end else begin
      if (m_ar.valid && m_ar_ready && m_ar.len == 8'd1) begin
        fetch_on_bus <= 1'b1;   // only a fetch asks for two beats.
      end
      if (fetch_req_valid && fetch_req_ready) begin
        fetch_beat <= 1'b0;
      end
      if (fetch_rsp.valid && fetch_rsp_ready) begin
        fetch_beat <= fetch_beat + 1'b1;
        if (fetch_rsp.last) begin
          fetch_on_bus <= 1'b0;
        end
      end
      if (lsu_rsp_valid && lsu_rsp_ready && !lsu_req_write &&
          lsu_req_addr == clint_mtime_lo_addr) begin
        last_lo <= lsu_rsp_data;
      end
    end
  end

  a_reset_state: assert property (@(posedge clock) $fell(reset) |->
      !fetch_rsp.valid && !lsu_rsp_valid && !m_ar.valid && !m_aw.valid && !m_w.valid &&
      fetch_req_ready && lsu_req_ready)
    else log_error("outputs are not idle after reset");

  a_fetch_data: assert property (@(posedge clock) disable iff (reset)
      fetch_rsp.valid && fetch_rsp_ready |->
      fetch_rsp.data == (fetch_beat ? fetch_second : fetch_first) &&
      fetch_rsp.last == fetch_beat && fetch_rsp.resp == 2'b00)
    else log_error($sformatf("fetch beat %0d returned %h", fetch_beat, fetch_rsp.data));

  a_fetch_hold: assert property (@(posedge clock) disable iff (reset)
      fetch_rsp.valid && !fetch_rsp_ready |=>
      fetch_rsp.valid && $stable(fetch_rsp.data) && $stable(fetch_rsp.last))
    else log_error("stalled fetch beat changed or vanished");

  a_lsu_read: assert property (@(posedge clock) disable iff (reset)
      lsu_rsp_valid && lsu_rsp_ready && lsu_mode == check_read |-> lsu_rsp_data == lsu_expect)
    else log_error($sformatf("load returned %h, expected %h", lsu_rsp_data, lsu_expect));

  a_lsu_okay: assert property (@(posedge clock) disable iff (reset)
      lsu_rsp_valid && lsu_rsp_ready |-> lsu_rsp_resp == 2'b00)
    else log_error("load/store response is not OKAY");

  a_mtime_rising: assert property (@(posedge clock) disable iff (reset)
      lsu_rsp_valid && lsu_rsp_ready && lsu_mode == check_lo |-> lsu_rsp_data > last_lo)
    else log_error($sformatf("mtime low word %h did not pass %h", lsu_rsp_data, last_lo));

  a_mtime_high: assert property (@(posedge clock) disable iff (reset)
      lsu_rsp_valid && lsu_rsp_ready && lsu_mode == check_hi |-> lsu_rsp_data == '0)
    else log_error($sformatf("mtime high word is %h", lsu_rsp_data));

  a_clint_local: assert property (@(posedge clock) disable iff (reset)
      m_ar.valid |-> m_ar.addr != clint_mtime_lo_addr && m_ar.addr != clint_mtime_hi_addr)
    else log_error("timer read went out on the external bus");

  a_lsu_first: assert property (@(posedge clock) disable iff (reset)
      fetch_rsp.valid |-> !lsu_first_pending)
    else log_error("fetch beat came before the competing load");

  a_fetch_holds_bus: assert property (@(posedge clock) disable iff (reset)
      m_aw.valid || (m_ar.valid && m_ar.len == 8'd0) |-> !fetch_on_bus)
    else log_error("load/store reached the bus during a fetch burst");

  a_axi_fixed: assert property (@(posedge clock) disable iff (reset)
      m_ar.valid || m_aw.valid || m_w.valid |->
      m_ar_burst == 2'b01 && m_aw_burst == 2'b01 && m_ar_id == '0 && m_aw_id == '0 &&
      (!m_w.valid || m_w_last))
    else log_error("burst type, id or write last is wrong");

  initial begin
    addr_t addr;
    data_t data;
    reset           = 1'b1;
    fetch_req_addr  = '0;
    fetch_req_valid = 1'b0;
    fetch_rsp_ready = 1'b1;
    lsu_req_addr    = '0;
    lsu_req_write   = 1'b0;
    lsu_req_size    = '0;
    lsu_req_wdata   = '0;
    lsu_req_valid   = 1'b0;
    lsu_rsp_ready   = 1'b1;
    repeat (2) @(posedge clock);
    reset <= 1'b0;
    @(posedge clock);
    repeat (3) begin
      start_fetch(random_address());
      wait_until(fetch_last, "end of a fetch burst");
    end
    addr       = random_address();
    rand_state = next_random(rand_state);
    data       = rand_state;
    lsu_access(1'b1, size_word, addr, data);
    lsu_access(1'b0, size_word, addr, '0);
    lsu_access(1'b1, 3'd0, addr + 32'd1, 32'h0000_00a5);
    lsu_access(1'b0, size_word, addr, '0);
    lsu_access(1'b1, 3'd1, addr + 32'd2, 32'h0000_c3d2);
    lsu_access(1'b0, size_word, addr, '0);
    start_fetch(addr);
    wait_until(fetch_last, "fetch of a written word");
    lsu_access(1'b0, size_word, clint_mtime_lo_addr, '0);
    lsu_access(1'b0, size_word, clint_mtime_lo_addr, '0);
    lsu_access(1'b0, size_word, clint_mtime_hi_addr, '0);
    addr              = random_address();
    lsu_first_pending = 1'b1;
    fork
      begin
        start_fetch(addr);
        wait_until(fetch_last, "fetch that raced a load");
      end
      begin
        lsu_access(1'b0, size_word, addr + 32'd8, '0);
        lsu_first_pending = 1'b0;
      end
    join
    addr = random_address();
    fetch_rsp_ready <= 1'b0;
    start_fetch(addr);
    wait_until(fetch_valid, "first beat of a stalled fetch");
    fork
      lsu_access(1'b0, size_word, addr + 32'd16, '0);
      begin
        repeat (4) @(posedge clock);
        fetch_rsp_ready <= 1'b1;
        wait_until(fetch_last, "end of the stalled fetch");
      end
    join
    repeat (2) @(posedge clock);
    $display("Run finished with %0d errors", error_count);
    if (error_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: soc_bus_top.f
soc_bus_pkg.sv
fetch_port.sv
load_store_port.sv
clint_timer.sv
bus_arbiter.sv
soc_bus_top.sv
tb_axi_memory.sv
tb_soc_bus.sv
